// File: hw/apr.sv
`timescale 1ns/1ps

module apr (
  input logic clk,
  input logic rst,
  input logic run,

  input logic cshAdrParErr,
  input logic mbParErr,
  input logic sbusErr,
  input logic nxmErr,
  input logic mboxCDirParErr,

  input cramPkg::crWord cr,

  output eboxPkg::errFlags errFlags,
  output logic errPending,
  output logic anyEboxError
);

  import eboxPkg::*;

  logic [0:ERR_COUNT-1] errIn;
  logic clearErr;

  always_comb begin
    errIn[ERR_CSH_ADR_PAR] = cshAdrParErr;
    errIn[ERR_MB_PAR] = mbParErr;
    errIn[ERR_SBUS] = sbusErr;
    errIn[ERR_NXM] = nxmErr;
    errIn[ERR_CDIR_PAR] = mboxCDirParErr;
  end

  // A frozen microword must not clear anything
  assign clearErr = run && cr.CLRERR;

  // New errors win over a clear at the same edge
  always_ff @(posedge clk) begin
    if (rst) begin
      errFlags <= '0;
    end else begin
      errFlags <= (clearErr ? '0 : errFlags) | errIn;
    end
  end

  assign errPending = |errFlags;
  assign anyEboxError = |errFlags;

endmodule

// File: hw/cra.sv
`timescale 1ns/1ps

module cra (
  input logic clk,
  input logic rst,
  input logic run,

  input logic adZero,
  input logic adNeg,
  input logic errPending,

  input cramPkg::crWord cr,

  output logic [cramPkg::CRAM_ADR_W-1:0] nextAdr,
  output logic [cramPkg::CRAM_ADR_W-1:0] crAdr
);

  import cramPkg::*;

  logic skip;

  // Skip condition select
  always_comb begin
    case (cr.SKIP)
      SKIP_AD_ZERO: skip = adZero;
      SKIP_AD_NEG: skip = adNeg;
      SKIP_ERR: skip = errPending;
      default: skip = 1'b0;
    endcase
  end

  // J with the skip bit ORed into the low address bit
  assign nextAdr = cr.J | CRAM_ADR_W'(skip);

  always_ff @(posedge clk) begin
    if (rst) begin
      crAdr <= CRAM_RESET_ADR;
    end else if (run) begin
      crAdr <= nextAdr;
    end
  end

  // The first fetch after reset comes from the reset address
  assert property (@(posedge clk) rst |=> crAdr == CRAM_RESET_ADR)
    else $error("crAdr not at reset address after reset");

endmodule

// File: hw/cram.sv
`timescale 1ns/1ps

module cram (
  input logic clk,
  input logic rst,
  input logic run,

  input logic cramWe,
  input logic [cramPkg::CRAM_ADR_W-1:0] cramWrAdr,
  input cramPkg::crWord cramWrData,

  input logic [cramPkg::CRAM_ADR_W-1:0] nextAdr,
  output cramPkg::crWord cr
);

  import cramPkg::*;

  // Writable control store
  logic [CR_W-1:0] store [CRAM_DEPTH];

  always_ff @(posedge clk) begin
    if (cramWe) begin
      store[cramWrAdr] <= cramWrData;
    end
  end

  // Microinstruction register, cleared to a no-op that jumps to 0
  always_ff @(posedge clk) begin
    if (rst) begin
      cr <= crWord'('0);
    end else if (run) begin
      cr <= crWord'(store[nextAdr]);
    end
  end

  // Store is only loaded while the machine is stopped
  assert property (@(posedge clk) disable iff (rst) !(cramWe && run))
    else $error("cram write while run is high");

endmodule

// File: hw/cramPkg.sv
package cramPkg;

  // Control store geometry
  localparam int CRAM_ADR_W = 8;
  localparam int CRAM_DEPTH = 256;
  localparam int CR_W = 18;

  // First microword fetched after reset
  localparam logic [CRAM_ADR_W-1:0] CRAM_RESET_ADR = '0;

  // Skip conditions, ORed into the low bit of J
  typedef enum logic [1:0] {
    SKIP_NEVER = 2'd0,
    SKIP_AD_ZERO = 2'd1,
    SKIP_AD_NEG = 2'd2,
    SKIP_ERR = 2'd3
  } skipT;

  // AD function, A is AR and B is BR
  typedef enum logic [1:0] {
    AD_ADD = 2'd0,
    AD_SUB = 2'd1,
    AD_AND = 2'd2,
    AD_OR = 2'd3
  } adFuncT;

  // AR load select
  typedef enum logic [1:0] {
    AR_HOLD = 2'd0,
    AR_AD = 2'd1,
    AR_CACHE = 2'd2,
    AR_CLR = 2'd3
  } arSelT;

  // Microword layout, J in the top bits and CLRERR in bit 0
  //   J       17:10
  //   SKIP     9:8
  //   ADFUNC   7:6
  //   ARSEL    5:4
  //   BRLOAD   3
  //   EBUSSEL  2:1
  //   CLRERR   0
  typedef struct packed {
    logic [CRAM_ADR_W-1:0] J;
    skipT SKIP;
    adFuncT ADFUNC;
    arSelT ARSEL;
    logic BRLOAD;
    eboxPkg::ebusSelT EBUSSEL;
    logic CLRERR;
  } crWord;

endpackage

// File: hw/ebox.sv
`timescale 1ns/1ps

module ebox (
  input logic clk,
  input logic rst,
  input logic run,

  input logic cramWe,
  input logic [cramPkg::CRAM_ADR_W-1:0] cramWrAdr,
  input cramPkg::crWord cramWrData,

  input eboxPkg::eboxWord cacheData,

  input logic cshAdrParErr,
  input logic mbParErr,
  input logic sbusErr,
  input logic nxmErr,
  input logic mboxCDirParErr,

  output logic [cramPkg::CRAM_ADR_W-1:0] crAdr,
  output eboxPkg::eboxWord ebus,
  output logic ebusValid,
  output logic anyEboxError
);

  import cramPkg::*;
  import eboxPkg::*;

  crWord cr;
  logic [CRAM_ADR_W-1:0] nextAdr;

  eboxWord ar;
  eboxWord ad;
  logic adZero;
  logic adNeg;

  eboxPkg::errFlags errFlags;
  logic errPending;

  cram cram0 (
    .clk(clk),
    .rst(rst),
    .run(run),
    .cramWe(cramWe),
    .cramWrAdr(cramWrAdr),
    .cramWrData(cramWrData),
    .nextAdr(nextAdr),
    .cr(cr)
  );

  apr apr0 (
    .clk(clk),
    .rst(rst),
    .run(run),
    .cshAdrParErr(cshAdrParErr),
    .mbParErr(mbParErr),
    .sbusErr(sbusErr),
    .nxmErr(nxmErr),
    .mboxCDirParErr(mboxCDirParErr),
    .cr(cr),
    .errFlags(errFlags),
    .errPending(errPending),
    .anyEboxError(anyEboxError)
  );

  cra cra0 (
    .clk(clk),
    .rst(rst),
    .run(run),
    .adZero(adZero),
    .adNeg(adNeg),
    .errPending(errPending),
    .cr(cr),
    .nextAdr(nextAdr),
    .crAdr(crAdr)
  );

  edp edp0 (
    .clk(clk),
    .rst(rst),
    .run(run),
    .cr(cr),
    .cacheData(cacheData),
    .ar(ar),
    .ad(ad),
    .adZero(adZero),
    .adNeg(adNeg)
  );

  ebus ebus0 (
    .clk(clk),
    .rst(rst),
    .run(run),
    .cr(cr),
    .ar(ar),
    .ad(ad),
    .errFlags(errFlags),
    .ebus(ebus),
    .ebusValid(ebusValid)
  );

endmodule

// File: hw/eboxPkg.sv
package eboxPkg;

  // Data word, MSB-0 numbering as on the real machine
  localparam int WORD_W = 36;

  typedef logic [0:WORD_W-1] eboxWord;

  // Sticky error sources collected by the APR
  localparam int ERR_COUNT = 5;

  typedef logic [0:ERR_COUNT-1] errFlags;

  // Bit positions within errFlags
  localparam int ERR_CSH_ADR_PAR = 0;
  localparam int ERR_MB_PAR = 1;
  localparam int ERR_SBUS = 2;
  localparam int ERR_NXM = 3;
  localparam int ERR_CDIR_PAR = 4;

  // EBUS driver codes
  typedef enum logic [1:0] {
    EBUS_NONE = 2'd0,
    EBUS_AR = 2'd1,
    EBUS_AD = 2'd2,
    EBUS_ERR = 2'd3
  } ebusSelT;

endpackage

// File: hw/ebus.sv
`timescale 1ns/1ps

module ebus (
  input logic clk,
  input logic rst,
  input logic run,

  input cramPkg::crWord cr,
  input eboxPkg::eboxWord ar,
  input eboxPkg::eboxWord ad,
  input eboxPkg::errFlags errFlags,

  output eboxPkg::eboxWord ebus,
  output logic ebusValid
);

  import eboxPkg::*;

  eboxWord busMux;
  logic drive;

  assign drive = run && (cr.EBUSSEL != EBUS_NONE);

  // Driver select, error flags land in bits 31 to 35
  always_comb begin
    busMux = '0;
    case (cr.EBUSSEL)
      EBUS_AR: busMux = ar;
      EBUS_AD: busMux = ad;
      EBUS_ERR: busMux[WORD_W-ERR_COUNT:WORD_W-1] = errFlags;
      default: busMux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ebus <= '0;
      ebusValid <= 1'b0;
    end else begin
      ebusValid <= drive;
      if (drive) begin
        ebus <= busMux;
      end
    end
  end

  // Back-to-back valids need two driving microwords in a row
  assert property (@(posedge clk) disable iff (rst)
    (ebusValid && $past(ebusValid)) |-> ($past(drive, 1) && $past(drive, 2)))
    else $error("ebusValid held without a driving microword");

endmodule

// File: hw/edp.sv
`timescale 1ns/1ps

module edp (
  input logic clk,
  input logic rst,
  input logic run,

  input cramPkg::crWord cr,
  input eboxPkg::eboxWord cacheData,

  output eboxPkg::eboxWord ar,
  output eboxPkg::eboxWord ad,
  output logic adZero,
  output logic adNeg
);

  import cramPkg::*;
  import eboxPkg::*;

  eboxWord br;

  // AD unit, results wrap at 36 bits
  always_comb begin
    case (cr.ADFUNC)
      AD_ADD: ad = ar + br;
      AD_SUB: ad = ar - br;
      AD_AND: ad = ar & br;
      default: ad = ar | br;
    endcase
  end

  assign adZero = (ad == '0);

  // Sign is bit 0
  assign adNeg = ad[0];

  // AR load
  always_ff @(posedge clk) begin
    if (rst) begin
      ar <= '0;
    end else if (run) begin
      case (cr.ARSEL)
        AR_AD: ar <= ad;
        AR_CACHE: ar <= cacheData;
        AR_CLR: ar <= '0;
        default: ar <= ar;
      endcase
    end
  end

  // BR takes the AR value from before this edge
  always_ff @(posedge clk) begin
    if (rst) begin
      br <= '0;
    end else if (run && cr.BRLOAD) begin
      br <= ar;
    end
  end

endmodule

// File: list.f
+incdir+tests
hw/eboxPkg.sv
hw/cramPkg.sv
hw/cram.sv
hw/cra.sv
hw/edp.sv
hw/apr.sv
hw/ebus.sv
hw/ebox.sv
tests/eboxTb.sv

// File: tests/eboxTbTable.svh
// Expected EBUS word kinds, turned into values by the reference model
localparam logic [1:0] K_AD = 2'd0;
localparam logic [1:0] K_AR = 2'd1;
localparam logic [1:0] K_NXM = 2'd2;
localparam logic [1:0] K_ZERO = 2'd3;

localparam int PROG_LEN = 7;
localparam int NUM_ROWS = 11;

// Up to three expected words, the first one in kinds[5:4]
typedef struct packed {
  logic prog;
  skipT skip;
  adFuncT func;
  logic randOps;
  logic nxmPulse;
  logic [3:0] stallAt;
  logic [35:0] a;
  logic [35:0] b;
  logic [1:0] nExp;
  logic [5:0] kinds;
} rowT;

// Columns are J, SKIP, ADFUNC, ARSEL, BRLOAD, EBUSSEL, CLRERR
// ADFUNC and a non-never SKIP are replaced from the row
localparam crWord PROGS [2][PROG_LEN] = '{
  // B then A into BR and AR, optional skip over the AR word
  '{
    '{8'd1, SKIP_NEVER, AD_ADD, AR_CACHE, 1'b0, EBUS_NONE, 1'b0},
    '{8'd2, SKIP_NEVER, AD_ADD, AR_HOLD, 1'b1, EBUS_NONE, 1'b0},
    '{8'd3, SKIP_NEVER, AD_ADD, AR_CACHE, 1'b0, EBUS_NONE, 1'b0},
    '{8'd4, SKIP_AD_ZERO, AD_ADD, AR_HOLD, 1'b0, EBUS_NONE, 1'b0},
    '{8'd5, SKIP_NEVER, AD_ADD, AR_HOLD, 1'b0, EBUS_AR, 1'b0},
    '{8'd6, SKIP_NEVER, AD_ADD, AR_HOLD, 1'b0, EBUS_AD, 1'b0},
    '{8'd6, SKIP_NEVER, AD_ADD, AR_HOLD, 1'b0, EBUS_NONE, 1'b0}
  },
  // Error flags out, clear, flags out again
  '{
    '{8'd1, SKIP_NEVER, AD_ADD, AR_HOLD, 1'b0, EBUS_NONE, 1'b0},
    '{8'd2, SKIP_NEVER, AD_ADD, AR_HOLD, 1'b0, EBUS_ERR, 1'b0},
    '{8'd3, SKIP_NEVER, AD_ADD, AR_HOLD, 1'b0, EBUS_NONE, 1'b1},
    '{8'd4, SKIP_NEVER, AD_ADD, AR_HOLD, 1'b0, EBUS_ERR, 1'b0},
    '{8'd4, SKIP_NEVER, AD_ADD, AR_HOLD, 1'b0, EBUS_NONE, 1'b0},
    '{8'd4, SKIP_NEVER, AD_ADD, AR_HOLD, 1'b0, EBUS_NONE, 1'b0},
    '{8'd4, SKIP_NEVER, AD_ADD, AR_HOLD, 1'b0, EBUS_NONE, 1'b0}
  }
};

// prog, skip, func, randOps, nxmPulse, stallAt, a, b, nExp, kinds
localparam rowT ROWS [NUM_ROWS] = '{
  '{1'b0, SKIP_NEVER, AD_ADD, 1'b1, 1'b0, 4'd0, 36'h0, 36'h0, 2'd2, {K_AR, K_AD, K_AD}},
  '{1'b0, SKIP_NEVER, AD_SUB, 1'b1, 1'b0, 4'd0, 36'h0, 36'h0, 2'd2, {K_AR, K_AD, K_AD}},
  '{1'b0, SKIP_NEVER, AD_AND, 1'b1, 1'b0, 4'd0, 36'h0, 36'h0, 2'd2, {K_AR, K_AD, K_AD}},
  '{1'b0, SKIP_NEVER, AD_OR, 1'b1, 1'b0, 4'd0, 36'h0, 36'h0, 2'd2, {K_AR, K_AD, K_AD}},
  '{1'b0, SKIP_NEVER, AD_ADD, 1'b0, 1'b0, 4'd0, 36'hfffffffff, 36'h1, 2'd2, {K_AR, K_AD, K_AD}},
  '{1'b0, SKIP_AD_ZERO, AD_SUB, 1'b0, 1'b0, 4'd0, 36'h5, 36'h5, 2'd1, {K_AD, K_AD, K_AD}},
  '{1'b0, SKIP_AD_ZERO, AD_SUB, 1'b0, 1'b0, 4'd0, 36'h123456789, 36'h5, 2'd2, {K_AR, K_AD, K_AD}},
  '{1'b0, SKIP_AD_NEG, AD_SUB, 1'b0, 1'b0, 4'd0, 36'h3, 36'h7, 2'd1, {K_AD, K_AD, K_AD}},
  '{1'b0, SKIP_AD_NEG, AD_SUB, 1'b0, 1'b0, 4'd0, 36'h7, 36'h3, 2'd2, {K_AR, K_AD, K_AD}},
  '{1'b1, SKIP_NEVER, AD_ADD, 1'b0, 1'b1, 4'd0, 36'h0, 36'h0, 2'd2, {K_NXM, K_ZERO, K_AD}},
  // Run drops between the AR word and the AD word
  '{1'b0, SKIP_NEVER, AD_ADD, 1'b1, 1'b0, 4'd6, 36'h0, 36'h0, 2'd2, {K_AR, K_AD, K_AD}}
};

// File: tests/eboxTb.sv
`timescale 1ns/1ps

module eboxTb;

  import cramPkg::*;
  import eboxPkg::*;

  `include "eboxTbTable.svh"

  localparam int STALL_CYCLES = 4;
  localparam int RUN_LIMIT = 16;

  logic clk;
  logic rst;
  logic run;
  logic cramWe;
  logic [CRAM_ADR_W-1:0] cramWrAdr;
  crWord cramWrData;
  eboxWord cacheData;
  logic cshAdrParErr;
  logic mbParErr;
  logic sbusErr;
  logic nxmErr;
  logic mboxCDirParErr;
  logic [CRAM_ADR_W-1:0] crAdr;
  eboxWord ebus;
  logic ebusValid;
  logic anyEboxError;

  int errCount = 0;
  int checkCount = 0;
  logic [31:0] lcgState = 32'hd80761b7;

  ebox u_ebox (.*);

  always #4 clk = ~clk;

  // Two LCG steps per 36-bit operand
  function automatic logic [35:0] lcgWord();
    logic [31:0] hi;
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    hi = lcgState;
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return {hi[31:28], lcgState};
  endfunction

  // Reference model for one EBUS word with A in AR and B in BR
  function automatic logic [35:0] expectedWord(logic [1:0] kind, logic [35:0] a,
                                               logic [35:0] b, adFuncT func);
    logic [35:0] ad;
    logic [35:0] w;
    case (func)
      AD_ADD: ad = a + b;
      AD_SUB: ad = a - b;
      AD_AND: ad = a & b;
      default: ad = a | b;
    endcase
    case (kind)
      K_AD: w = ad;
      K_AR: w = a;
      // NXM is flag 3 of 5 in bits 31 to 35 and lands in word bit 34
      K_NXM: w = 36'd2;
      default: w = 36'd0;
    endcase
    return w;
  endfunction

  task automatic runRow(input int idx);
    rowT r;
    crWord w;
    logic [35:0] a;
    logic [35:0] b;
    logic [35:0] expQ [$];
    logic [CRAM_ADR_W-1:0] heldAdr;
    logic runWasHigh;
    int runEdges;
    int drain;
    int stallLeft;
    int errAtStart;
    r = ROWS[idx];
    errAtStart = errCount;
    a = r.randOps ? lcgWord() : r.a;
    b = r.randOps ? lcgWord() : r.b;
    for (int k = 0; k < r.nExp; k++) begin
      expQ.push_back(expectedWord(r.kinds[5-2*k -: 2], a, b, r.func));
    end

    rst <= 1'b1;
    run <= 1'b0;
    cacheData <= b;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    checkCount += 3;
    if (crAdr !== CRAM_RESET_ADR) begin
      $display("Fail at %0t: crAdr expected %h got %h", $time, CRAM_RESET_ADR, crAdr);
      errCount++;
    end
    if (ebusValid !== 1'b0) begin
      $display("Fail at %0t: ebusValid expected 0 got %b", $time, ebusValid);
      errCount++;
    end
    if (anyEboxError !== 1'b0) begin
      $display("Fail at %0t: anyEboxError expected 0 got %b", $time, anyEboxError);
      errCount++;
    end

    for (int k = 0; k < PROG_LEN; k++) begin
      w = PROGS[r.prog][k];
      w.ADFUNC = r.func;
      if (w.SKIP != SKIP_NEVER) begin
        w.SKIP = r.skip;
      end
      cramWe <= 1'b1;
      cramWrAdr <= CRAM_ADR_W'(k);
      cramWrData <= w;
      @(posedge clk);
    end
    cramWe <= 1'b0;

    if (r.nxmPulse) begin
      nxmErr <= 1'b1;
      @(posedge clk);
      nxmErr <= 1'b0;
      // Flag stays up with the input gone
      repeat (3) begin
        @(posedge clk);
        checkCount++;
        if (anyEboxError !== 1'b1) begin
          $display("Fail at %0t: anyEboxError expected 1 got %b", $time, anyEboxError);
          errCount++;
        end
      end
    end

    run <= 1'b1;
    runEdges = 0;
    drain = 0;
    stallLeft = 0;
    while (drain < 3 && runEdges < RUN_LIMIT) begin
      @(posedge clk);
      // Outputs read here hold their values from the cycle just ended
      runWasHigh = run;
      if (ebusValid) begin
        checkCount++;
        if (expQ.size() == 0) begin
          $display("Unexpected ebusValid at %0t in test %0d", $time, idx);
          errCount++;
        end else begin
          if (ebus !== expQ[0]) begin
            $display("Fail at %0t: ebus expected %h got %h", $time, expQ[0], ebus);
            errCount++;
          end
          void'(expQ.pop_front());
        end
      end
      if (stallLeft > 0) begin
        if (stallLeft == STALL_CYCLES) begin
          // Program 0 without a skip moves one address per run edge
          heldAdr = CRAM_ADR_W'(r.stallAt - 1);
        end else begin
          checkCount++;
          if (crAdr !== heldAdr) begin
            $display("Fail at %0t: crAdr expected %h got %h", $time, heldAdr, crAdr);
            errCount++;
          end
          if (ebusValid !== 1'b0) begin
            $display("ebusValid came up at %0t while run was low", $time);
            errCount++;
          end
        end
        stallLeft--;
        if (stallLeft == 0) begin
          run <= 1'b1;
        end
      end
      if (runWasHigh) begin
        runEdges++;
        if (runEdges == r.stallAt) begin
          run <= 1'b0;
          stallLeft = STALL_CYCLES;
        end
      end
      // B goes into AR first and A after it
      cacheData <= (runEdges >= 2) ? a : b;
      if (expQ.size() == 0) begin
        drain++;
      end
    end
    run <= 1'b0;

    if (expQ.size() != 0) begin
      $display("Test %0d ended with %0d EBUS words missing", idx, expQ.size());
      errCount++;
    end
    checkCount++;
    if (anyEboxError !== 1'b0) begin
      $display("Fail at %0t: anyEboxError expected 0 got %b", $time, anyEboxError);
      errCount++;
    end
    if (errCount == errAtStart) begin
      $display("Test %0d passed", idx);
    end else begin
      $display("Test %0d failed with %0d mismatches", idx, errCount - errAtStart);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    run = 1'b0;
    cramWe = 1'b0;
    cramWrAdr = '0;
    cramWrData = '0;
    cacheData = '0;
    cshAdrParErr = 1'b0;
    mbParErr = 1'b0;
    sbusErr = 1'b0;
    nxmErr = 1'b0;
    mboxCDirParErr = 1'b0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      runRow(i);
    end
    $display("Tests %0d, checks %0d, failures %0d", NUM_ROWS, checkCount, errCount);
    if (errCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog allows 40 cycles per row plus margin
  initial begin
    #((NUM_ROWS * 40 + 200) * 8);
    $display("Timeout at %0t, the tests did not finish", $time);
    $display("Errors found");
    $finish;
  end

endmodule
